//--- rv_id_pkg.sv
package rv_id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [31:0]           inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            funct7_t;

    // major opcodes
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    // alu group, shared by OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // add/srl vs sub/sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    typedef enum logic [5:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LB, ALU_LH, ALU_LW,
        ALU_LBU, ALU_LHU, ALU_SB, ALU_SH, ALU_SW, ALU_BEQ, ALU_BNE,
        ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU, ALU_JAL, ALU_JALR, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_LD_ST, SEL_JAL
    } alu_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        alu_sel_e alu_sel;
        logic     wreg;
        logic     rs1_rd;
        logic     rs2_rd;
        imm_sel_e imm_sel;
    } ctrl_t;

    // instruction currently in EX
    typedef struct packed {
        logic      ld;
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } ex_fwd_t;

    typedef struct packed {
        alu_op_e   alu_op;
        alu_sel_e  alu_sel;
        word_t     op1;
        word_t     op2;
        word_t     offset;
        reg_addr_t wd;
        logic      wreg;
    } id_ex_t;

    localparam id_ex_t ID_EX_BUBBLE = '{
        alu_op:  ALU_NOP,
        alu_sel: SEL_NOP,
        op1:     '0,
        op2:     '0,
        offset:  '0,
        wd:      '0,
        wreg:    1'b0
    };

endpackage

//--- id_ctrl_dec.sv
`timescale 1ns/10ps

module id_ctrl_dec (
    input  rv_id_pkg::inst_t inst_i,
    output rv_id_pkg::ctrl_t ctrl_o
);
    import rv_id_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    alu_op_e alu_op;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // result class of an OP / OP-IMM operation
    function automatic alu_sel_e alu_class(input alu_op_e op);
        alu_sel_e cls;
        case (op)
            ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: cls = SEL_ARITH;
            ALU_SLL, ALU_SRL, ALU_SRA:           cls = SEL_SHIFT;
            default:                             cls = SEL_LOGIC;
        endcase
        return cls;
    endfunction

    // operation per encoding, ALU_NOP marks an illegal one
    always_comb begin
        alu_op = ALU_NOP;
        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                case (funct3)
                    F3_ADD: begin
                        if (opcode == OPC_OP_IMM || funct7 == F7_BASE) begin
                            alu_op = ALU_ADD;
                        end else if (funct7 == F7_ALT) begin
                            alu_op = ALU_SUB;
                        end
                    end
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_SLTU: alu_op = ALU_SLTU;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SRL: begin
                        if (funct7 == F7_BASE) begin
                            alu_op = ALU_SRL;
                        end else if (funct7 == F7_ALT) begin
                            alu_op = ALU_SRA;
                        end
                    end
                    default: alu_op = ALU_NOP;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_LB:   alu_op = ALU_LB;
                    F3_LH:   alu_op = ALU_LH;
                    F3_LW:   alu_op = ALU_LW;
                    F3_LBU:  alu_op = ALU_LBU;
                    F3_LHU:  alu_op = ALU_LHU;
                    default: alu_op = ALU_NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_SB:   alu_op = ALU_SB;
                    F3_SH:   alu_op = ALU_SH;
                    F3_SW:   alu_op = ALU_SW;
                    default: alu_op = ALU_NOP;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  alu_op = ALU_BEQ;
                    F3_BNE:  alu_op = ALU_BNE;
                    F3_BLT:  alu_op = ALU_BLT;
                    F3_BGE:  alu_op = ALU_BGE;
                    F3_BLTU: alu_op = ALU_BLTU;
                    F3_BGEU: alu_op = ALU_BGEU;
                    default: alu_op = ALU_NOP;
                endcase
            end
            OPC_JAL:   alu_op = ALU_JAL;
            OPC_JALR:  alu_op = ALU_JALR;
            OPC_LUI:   alu_op = ALU_OR;
            OPC_AUIPC: alu_op = ALU_AUIPC;
            default:   alu_op = ALU_NOP;
        endcase
    end

    // class, register use and immediate format per group
    always_comb begin
        ctrl_o = '{alu_op: ALU_NOP, alu_sel: SEL_NOP, wreg: 1'b0,
                   rs1_rd: 1'b0, rs2_rd: 1'b0, imm_sel: IMM_NONE};
        if (alu_op != ALU_NOP) begin
            ctrl_o.alu_op = alu_op;
            case (opcode)
                OPC_OP_IMM: begin
                    ctrl_o.alu_sel = alu_class(alu_op);
                    ctrl_o.wreg    = 1'b1;
                    ctrl_o.rs1_rd  = 1'b1;
                    ctrl_o.imm_sel = (alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) ?
                                     IMM_SHAMT : IMM_I;
                end
                OPC_OP: begin
                    ctrl_o.alu_sel = alu_class(alu_op);
                    ctrl_o.wreg    = 1'b1;
                    ctrl_o.rs1_rd  = 1'b1;
                    ctrl_o.rs2_rd  = 1'b1;
                end
                OPC_LOAD: begin
                    ctrl_o.alu_sel = SEL_LD_ST;
                    ctrl_o.wreg    = 1'b1;
                    ctrl_o.rs1_rd  = 1'b1;
                    ctrl_o.imm_sel = IMM_I;
                end
                OPC_STORE: begin
                    ctrl_o.alu_sel = SEL_LD_ST;
                    ctrl_o.rs1_rd  = 1'b1;
                    ctrl_o.rs2_rd  = 1'b1;
                    ctrl_o.imm_sel = IMM_S;
                end
                OPC_BRANCH: begin
                    ctrl_o.rs1_rd  = 1'b1;
                    ctrl_o.rs2_rd  = 1'b1;
                    ctrl_o.imm_sel = IMM_B;
                end
                OPC_JAL: begin
                    ctrl_o.alu_sel = SEL_JAL;
                    ctrl_o.wreg    = 1'b1;
                    ctrl_o.imm_sel = IMM_J;
                end
                OPC_JALR: begin
                    ctrl_o.alu_sel = SEL_JAL;
                    ctrl_o.wreg    = 1'b1;
                    ctrl_o.rs1_rd  = 1'b1;
                    ctrl_o.imm_sel = IMM_I;
                end
                OPC_LUI: begin
                    // lui is 0 | imm, both operands carry the immediate
                    ctrl_o.alu_sel = SEL_LOGIC;
                    ctrl_o.wreg    = 1'b1;
                    ctrl_o.imm_sel = IMM_U;
                end
                OPC_AUIPC: begin
                    ctrl_o.alu_sel = SEL_ARITH;
                    ctrl_o.wreg    = 1'b1;
                    ctrl_o.imm_sel = IMM_U;
                end
                default: begin
                    ctrl_o.alu_op = ALU_NOP;
                end
            endcase
        end
    end

endmodule

//--- id_imm_gen.sv
`timescale 1ns/10ps

module id_imm_gen (
    input  rv_id_pkg::inst_t    inst_i,
    input  rv_id_pkg::imm_sel_e imm_sel_i,
    output rv_id_pkg::word_t    imm_o
);
    import rv_id_pkg::*;

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (imm_sel_i)
            IMM_I: begin
                imm_o = {{20{sign}}, inst_i[31:20]};
            end
            IMM_SHAMT: begin
                imm_o = {27'b0, inst_i[24:20]};
            end
            IMM_S: begin
                imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            IMM_B: begin
                // branch offsets are halfword aligned
                imm_o = {{19{sign}}, sign, inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{11{sign}}, sign, inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

//--- id_operand_sel.sv
`timescale 1ns/10ps

module id_operand_sel (
    input  logic                rd_en_i,
    input  rv_id_pkg::reg_addr_t addr_i,
    input  rv_id_pkg::word_t    rf_data_i,
    input  rv_id_pkg::word_t    imm_i,
    input  rv_id_pkg::ex_fwd_t  ex_fwd_i,
    output rv_id_pkg::word_t    operand_o,
    output logic                stall_o
);

    logic ex_hit;
    logic load_use;
    logic fwd_hit;

    // full address compare, x0 is not special
    assign ex_hit   = rd_en_i && (ex_fwd_i.wd == addr_i);
    assign load_use = ex_hit && ex_fwd_i.ld;
    assign fwd_hit  = ex_hit && ex_fwd_i.wreg;

    assign stall_o = load_use;

    always_comb begin
        if (load_use) begin
            // data not ready yet, stage is stalled anyway
            operand_o = '0;
        end else if (fwd_hit) begin
            operand_o = ex_fwd_i.wdata;
        end else if (rd_en_i) begin
            operand_o = rf_data_i;
        end else begin
            operand_o = imm_i;
        end
    end

endmodule

//--- id_stage.sv
`timescale 1ns/10ps

module id_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  rv_id_pkg::inst_t     inst_i,
    input  rv_id_pkg::word_t     rs1_data_i,
    input  rv_id_pkg::word_t     rs2_data_i,
    input  rv_id_pkg::ex_fwd_t   ex_fwd_i,
    output rv_id_pkg::reg_addr_t rs1_addr_o,
    output rv_id_pkg::reg_addr_t rs2_addr_o,
    output logic                 rs1_rd_o,
    output logic                 rs2_rd_o,
    output rv_id_pkg::id_ex_t    ex_o,
    output logic                 stall_o
);
    import rv_id_pkg::*;

    ctrl_t     ctrl;
    word_t     imm;
    word_t     opnd1;
    word_t     opnd2;
    logic      stall1;
    logic      stall2;
    reg_addr_t rd;
    id_ex_t    ex_d;

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd         = inst_i[11:7];

    assign rs1_rd_o = ctrl.rs1_rd;
    assign rs2_rd_o = ctrl.rs2_rd;

    id_ctrl_dec u_ctrl_dec (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    id_imm_gen u_imm_gen (
        .inst_i    (inst_i),
        .imm_sel_i (ctrl.imm_sel),
        .imm_o     (imm)
    );

    id_operand_sel u_op1_sel (
        .rd_en_i   (ctrl.rs1_rd),
        .addr_i    (rs1_addr_o),
        .rf_data_i (rs1_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .operand_o (opnd1),
        .stall_o   (stall1)
    );

    id_operand_sel u_op2_sel (
        .rd_en_i   (ctrl.rs2_rd),
        .addr_i    (rs2_addr_o),
        .rf_data_i (rs2_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .operand_o (opnd2),
        .stall_o   (stall2)
    );

    assign stall_o = stall1 | stall2;

    // offset carries the immediate for stores and branches
    assign ex_d = '{alu_op:  ctrl.alu_op,
                    alu_sel: ctrl.alu_sel,
                    op1:     opnd1,
                    op2:     opnd2,
                    offset:  imm,
                    wd:      rd,
                    wreg:    ctrl.wreg};

    // id/ex register, bubble on load-use stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o <= ID_EX_BUBBLE;
        end else if (stall_o) begin
            ex_o <= ID_EX_BUBBLE;
        end else begin
            ex_o <= ex_d;
        end
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release lands on a rising edge
    initial begin
        arst_n_o <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

//--- id_stage_assert.sv
`timescale 1ns/10ps

module id_stage_assert (
    input logic               clk,
    input logic               arst_n_i,
    input logic               stall_i,
    input rv_id_pkg::ex_fwd_t ex_fwd_i,
    input rv_id_pkg::id_ex_t  ex_i
);
    import rv_id_pkg::*;

    int fail_cnt = 0;

    no_write_in_reset: assert property (@(posedge clk) !arst_n_i |-> !ex_i.wreg)
        else begin
            fail_cnt++;
            $error("ex_o.wreg is set while reset is active");
        end

    // a stalled instruction must not reach EX
    bubble_after_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
                                         stall_i |=> (ex_i == ID_EX_BUBBLE))
        else begin
            fail_cnt++;
            $error("ex_o is not a bubble after a stall");
        end

    stall_needs_load: assert property (@(posedge clk) disable iff (!arst_n_i)
                                       stall_i |-> ex_fwd_i.ld)
        else begin
            fail_cnt++;
            $error("stall_o is high without a load in EX");
        end

endmodule

//--- id_stage_tb.sv
`timescale 1ns/10ps

module id_stage_tb;
    import rv_id_pkg::*;

    localparam int N_TESTS    = 6;
    localparam int N_INST     = 40;
    localparam int CLK_NS     = 4;
    localparam int TIMEOUT_NS = 2 * N_TESTS * N_INST * CLK_NS;

    typedef struct packed {
        id_ex_t    bundle;
        logic      stall;
        logic      rd1;
        logic      rd2;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } expect_t;

    logic      clk;
    logic      arst_n;
    inst_t     inst;
    word_t     rs1_data;
    word_t     rs2_data;
    ex_fwd_t   ex_fwd;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      rs1_rd;
    logic      rs2_rd;
    id_ex_t    ex;
    logic      stall;

    integer  seed = 32'hbfe0d395;
    expect_t exp_q[$];
    int      sent_cnt = 0;
    int      done_cnt = 0;
    int      checks = 0;
    int      errors = 0;
    int      mark_checks = 0;
    int      mark_errors = 0;
    logic    reset_done = 1'b0;

    tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(10)) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    id_stage dut (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .inst_i     (inst),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_fwd_i   (ex_fwd),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_rd_o   (rs1_rd),
        .rs2_rd_o   (rs2_rd),
        .ex_o       (ex),
        .stall_o    (stall)
    );

    bind id_stage id_stage_assert u_assert (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_o),
        .ex_fwd_i (ex_fwd_i),
        .ex_i     (ex_o)
    );

    task automatic check_bundle(input string name, input id_ex_t got, input id_ex_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: stall_o is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic word_t operand_ref(input logic rd, input reg_addr_t a, input word_t rf,
                                          input word_t imm, input ex_fwd_t fwd);
        if (!rd) return imm;
        if (fwd.wd != a) return rf;
        if (fwd.ld) return '0;
        return fwd.wreg ? fwd.wdata : rf;
    endfunction

    // expected bundle from the decode, immediate and operand rules
    function automatic id_ex_t decode_ref(input inst_t in, input word_t d1, input word_t d2,
                                          input ex_fwd_t fwd, output logic stall_exp,
                                          output logic rd1, output logic rd2);
        id_ex_t     b;
        opcode_t    opc;
        logic [2:0] f3;
        logic       alt;
        word_t      imm;
        opc    = in[6:0];
        f3     = in[14:12];
        alt    = (in[31:25] == F7_ALT);
        b      = ID_EX_BUBBLE;
        b.wd   = in[11:7];
        b.wreg = 1'b1;
        rd1    = 1'b0;
        rd2    = 1'b0;
        imm    = '0;
        case (opc)
            OPC_OP_IMM, OPC_OP: begin
                rd1 = 1'b1;
                rd2 = (opc == OPC_OP);
                case (f3)
                    3'b000:  b.alu_op = (rd2 && alt) ? ALU_SUB : ALU_ADD;
                    3'b001:  b.alu_op = ALU_SLL;
                    3'b010:  b.alu_op = ALU_SLT;
                    3'b011:  b.alu_op = ALU_SLTU;
                    3'b100:  b.alu_op = ALU_XOR;
                    3'b101:  b.alu_op = alt ? ALU_SRA : ALU_SRL;
                    3'b110:  b.alu_op = ALU_OR;
                    default: b.alu_op = ALU_AND;
                endcase
                if (f3 == 3'b000 || f3 == 3'b010 || f3 == 3'b011) begin
                    b.alu_sel = SEL_ARITH;
                end else if (f3 == 3'b001 || f3 == 3'b101) begin
                    b.alu_sel = SEL_SHIFT;
                end else begin
                    b.alu_sel = SEL_LOGIC;
                end
                if (!rd2 && (f3 == 3'b001 || f3 == 3'b101)) begin
                    imm = {27'd0, in[24:20]};
                end else if (!rd2) begin
                    imm = {{20{in[31]}}, in[31:20]};
                end
            end
            OPC_LOAD: begin
                rd1       = 1'b1;
                b.alu_sel = SEL_LD_ST;
                imm       = {{20{in[31]}}, in[31:20]};
                case (f3)
                    3'b000:  b.alu_op = ALU_LB;
                    3'b001:  b.alu_op = ALU_LH;
                    3'b010:  b.alu_op = ALU_LW;
                    3'b100:  b.alu_op = ALU_LBU;
                    default: b.alu_op = ALU_LHU;
                endcase
            end
            OPC_STORE: begin
                rd1       = 1'b1;
                rd2       = 1'b1;
                b.wreg    = 1'b0;
                b.alu_sel = SEL_LD_ST;
                imm       = {{20{in[31]}}, in[31:25], in[11:7]};
                case (f3)
                    3'b000:  b.alu_op = ALU_SB;
                    3'b001:  b.alu_op = ALU_SH;
                    default: b.alu_op = ALU_SW;
                endcase
            end
            OPC_BRANCH: begin
                rd1    = 1'b1;
                rd2    = 1'b1;
                b.wreg = 1'b0;
                imm    = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
                case (f3)
                    3'b000:  b.alu_op = ALU_BEQ;
                    3'b001:  b.alu_op = ALU_BNE;
                    3'b100:  b.alu_op = ALU_BLT;
                    3'b101:  b.alu_op = ALU_BGE;
                    3'b110:  b.alu_op = ALU_BLTU;
                    default: b.alu_op = ALU_BGEU;
                endcase
            end
            OPC_JAL: begin
                b.alu_op  = ALU_JAL;
                b.alu_sel = SEL_JAL;
                imm       = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
            end
            OPC_JALR: begin
                rd1       = 1'b1;
                b.alu_op  = ALU_JALR;
                b.alu_sel = SEL_JAL;
                imm       = {{20{in[31]}}, in[31:20]};
            end
            OPC_LUI: begin
                b.alu_op  = ALU_OR;
                b.alu_sel = SEL_LOGIC;
                imm       = {in[31:12], 12'h000};
            end
            OPC_AUIPC: begin
                b.alu_op  = ALU_AUIPC;
                b.alu_sel = SEL_ARITH;
                imm       = {in[31:12], 12'h000};
            end
            default: begin
                b.wreg = 1'b0;
            end
        endcase
        stall_exp = (rd1 && fwd.ld && fwd.wd == in[19:15]) ||
                    (rd2 && fwd.ld && fwd.wd == in[24:20]);
        b.op1    = operand_ref(rd1, in[19:15], d1, imm, fwd);
        b.op2    = operand_ref(rd2, in[24:20], d2, imm, fwd);
        b.offset = imm;
        return stall_exp ? ID_EX_BUBBLE : b;
    endfunction

    // random OP or OP-IMM with a legal funct7
    function automatic inst_t alu_inst(input logic [31:0] r);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = r[14:12];
        if (r[5]) begin
            f7 = (r[30] && (f3 == F3_ADD || f3 == F3_SRL)) ? F7_ALT : F7_BASE;
            return {f7, r[24:15], f3, r[11:7], OPC_OP};
        end
        if (f3 == F3_SLL) begin
            f7 = F7_BASE;
        end else if (f3 == F3_SRL) begin
            f7 = r[30] ? F7_ALT : F7_BASE;
        end else begin
            f7 = r[31:25];
        end
        return {f7, r[24:15], f3, r[11:7], OPC_OP_IMM};
    endfunction

    // random instruction of the other kept groups
    function automatic inst_t mem_inst(input logic [31:0] r);
        logic [2:0] f3;
        opcode_t    opc;
        f3 = r[14:12];
        case (r[3:1])
            3'd0: begin
                opc = OPC_LOAD;
                if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = 3'b010;
            end
            3'd1: begin
                opc = OPC_STORE;
                f3  = {1'b0, f3[1:0]};
                if (f3 == 3'b011) f3 = 3'b010;
            end
            3'd2: begin
                opc = OPC_BRANCH;
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
            end
            3'd3: opc = OPC_JAL;
            3'd4: begin
                opc = OPC_JALR;
                f3  = 3'b000;
            end
            3'd5: opc = OPC_LUI;
            default: opc = OPC_AUIPC;
        endcase
        return {r[31:15], f3, r[11:7], opc};
    endfunction

    function automatic inst_t illegal_inst(input logic [31:0] r);
        opcode_t opc;
        opc = r[6:0];
        while (opc inside {OPC_OP_IMM, OPC_OP, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                           OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC}) begin
            opc = opc + 7'd1;
        end
        return {r[31:7], opc};
    endfunction

    task automatic drive(input inst_t in, input ex_fwd_t fwd);
        expect_t e;
        @(negedge clk);
        inst     = in;
        ex_fwd   = fwd;
        rs1_data = $random(seed);
        rs2_data = $random(seed);
        e.bundle = decode_ref(in, rs1_data, rs2_data, fwd, e.stall, e.rd1, e.rd2);
        e.rs1    = in[19:15];
        e.rs2    = in[24:20];
        exp_q.push_back(e);
        sent_cnt++;
    endtask

    task automatic finish_test(input string name);
        wait (done_cnt == sent_cnt);
        $display("test %-10s %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // comb outputs on the rising edge, ex_o on the falling edge after it
    initial begin : compare
        expect_t e;
        @(negedge clk);
        while (!arst_n) begin
            check_bundle("ex_o", ex, ID_EX_BUBBLE);
            check_stall(stall, 1'b0);
            @(negedge clk);
        end
        @(negedge clk);
        check_bundle("ex_o", ex, ID_EX_BUBBLE);
        check_stall(stall, 1'b0);
        reset_done = 1'b1;
        forever begin
            @(posedge clk);
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_stall(stall, e.stall);
                check_flag("rs1_rd_o", rs1_rd, e.rd1);
                check_flag("rs2_rd_o", rs2_rd, e.rd2);
                check_addr("rs1_addr_o", rs1_addr, e.rs1);
                check_addr("rs2_addr_o", rs2_addr, e.rs2);
                @(negedge clk);
                check_bundle("ex_o", ex, e.bundle);
                done_cnt++;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        logic [31:0] r;
        inst_t       in;
        ex_fwd_t     fwd;
        inst     = '0;
        rs1_data = '0;
        rs2_data = '0;
        ex_fwd   = '0;
        wait (reset_done);
        finish_test("reset");

        repeat (N_INST) drive(alu_inst($random(seed)), '0);
        finish_test("alu");

        repeat (N_INST) drive(mem_inst($random(seed)), '0);
        finish_test("imm");

        // EX result forwarded to rs1, rs2 or both
        repeat (N_INST) begin
            r    = $random(seed);
            r[5] = 1'b1;
            in   = alu_inst(r);
            if (r[1:0] == 2'b10) begin
                in[24:20] = in[19:15];
            end
            fwd.ld    = 1'b0;
            fwd.wreg  = 1'b1;
            fwd.wd    = r[0] ? in[24:20] : in[19:15];
            fwd.wdata = $random(seed);
            drive(in, fwd);
        end
        finish_test("forward");

        // load in EX, match may hit an unread source
        repeat (N_INST) begin
            r         = $random(seed);
            in        = r[6] ? alu_inst(r) : mem_inst(r);
            fwd.ld    = 1'b1;
            fwd.wreg  = 1'b1;
            fwd.wd    = r[4] ? in[24:20] : in[19:15];
            fwd.wdata = $random(seed);
            drive(in, fwd);
        end
        finish_test("load-use");

        repeat (N_INST) begin
            r         = $random(seed);
            in        = illegal_inst(r);
            fwd.ld    = 1'b1;
            fwd.wreg  = 1'b1;
            fwd.wd    = in[19:15];
            fwd.wdata = $random(seed);
            drive(in, fwd);
        end
        finish_test("illegal");

        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 dut.u_assert.fail_cnt);
        if (errors == 0 && dut.u_assert.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rv_id.f
rv_id_pkg.sv
id_ctrl_dec.sv
id_imm_gen.sv
id_operand_sel.sv
id_stage.sv
tb_clk_gen.sv
id_stage_assert.sv
id_stage_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := id_stage_tb
FILELIST := rv_id.f
OBJ_DIR  := obj_dir
LOG      := sim.log
RUN_ARGS := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "no pass line"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
